// ==== rtl/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

    typedef logic [31:0] instrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regAddrT;
    typedef logic [1:0]  stageCntT;   // use time / new time, in stages

    // opcode field
    localparam opcodeT opZero = 6'b000000;   // R-type, look at funct
    localparam opcodeT opAddi = 6'b001000;
    localparam opcodeT opAndi = 6'b001100;
    localparam opcodeT opOri  = 6'b001101;
    localparam opcodeT opLui  = 6'b001111;
    localparam opcodeT opBeq  = 6'b000100;
    localparam opcodeT opBne  = 6'b000101;
    localparam opcodeT opJ    = 6'b000010;
    localparam opcodeT opJal  = 6'b000011;
    localparam opcodeT opLw   = 6'b100011;
    localparam opcodeT opLh   = 6'b100001;
    localparam opcodeT opLhu  = 6'b100101;
    localparam opcodeT opLb   = 6'b100000;
    localparam opcodeT opLbu  = 6'b100100;
    localparam opcodeT opSw   = 6'b101011;
    localparam opcodeT opSh   = 6'b101001;
    localparam opcodeT opSb   = 6'b101000;

    // funct field of R-type
    localparam functT functAdd  = 6'b100000;
    localparam functT functSub  = 6'b100010;
    localparam functT functAnd  = 6'b100100;
    localparam functT functOr   = 6'b100101;
    localparam functT functSlt  = 6'b101010;
    localparam functT functSltu = 6'b101011;
    localparam functT functJr   = 6'b001000;
    localparam functT functJalr = 6'b001001;

    localparam regAddrT  raRegAddr = 5'd31;   // link register for jal
    localparam stageCntT tuseNever = 2'd3;    // source not read

    typedef enum logic [4:0] {
        kindAdd, kindSub, kindAnd, kindOr, kindSlt, kindSltu,
        kindJr, kindJalr,
        kindAddi, kindAndi, kindOri, kindLui,
        kindBeq, kindBne, kindJ, kindJal,
        kindLw, kindLh, kindLhu, kindLb, kindLbu,
        kindSw, kindSh, kindSb,
        kindIllegal
    } instrKindE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSltu} aluOpE;

    typedef enum logic [1:0] {cmpNone, cmpEq, cmpNe} cmpOpE;

    typedef enum logic [1:0] {extZero, extSign, extHigh} extOpE;

    typedef enum logic [1:0] {npcSeq, npcBranch, npcJumpInstr, npcJumpReg} npcSelE;

    typedef enum logic [1:0] {alignWord, alignHalf, alignByte} dmAlignE;

    typedef enum logic [1:0] {wdAlu, wdMem, wdPcPlus8} regWdSelE;

endpackage

// ==== rtl/instrDecode.sv ====
`timescale 1ns/1ns

module instrDecode (
    input  mipsCtrlPkg::instrT     instr,
    output mipsCtrlPkg::instrKindE kind,
    output mipsCtrlPkg::regAddrT   rs,
    output mipsCtrlPkg::regAddrT   rt,
    output mipsCtrlPkg::regAddrT   rd
);
    import mipsCtrlPkg::*;

    opcodeT opcode;
    functT  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        if (opcode == opZero) begin
            case (funct)
                functAdd:  kind = kindAdd;
                functSub:  kind = kindSub;
                functAnd:  kind = kindAnd;
                functOr:   kind = kindOr;
                functSlt:  kind = kindSlt;
                functSltu: kind = kindSltu;
                functJr:   kind = kindJr;
                functJalr: kind = kindJalr;
                default:   kind = kindIllegal;   // incl. mult/div group
            endcase
        end else begin
            case (opcode)
                opAddi:  kind = kindAddi;
                opAndi:  kind = kindAndi;
                opOri:   kind = kindOri;
                opLui:   kind = kindLui;
                opBeq:   kind = kindBeq;
                opBne:   kind = kindBne;
                opJ:     kind = kindJ;
                opJal:   kind = kindJal;
                opLw:    kind = kindLw;
                opLh:    kind = kindLh;
                opLhu:   kind = kindLhu;
                opLb:    kind = kindLb;
                opLbu:   kind = kindLbu;
                opSw:    kind = kindSw;
                opSh:    kind = kindSh;
                opSb:    kind = kindSb;
                default: kind = kindIllegal;
            endcase
        end
    end

endmodule

// ==== rtl/controlTable.sv ====
`timescale 1ns/1ns

module controlTable (
    input  mipsCtrlPkg::instrKindE kind,
    input  mipsCtrlPkg::regAddrT   rt,
    input  mipsCtrlPkg::regAddrT   rd,
    output mipsCtrlPkg::cmpOpE     cmpOp,
    output mipsCtrlPkg::extOpE     extOp,
    output mipsCtrlPkg::npcSelE    npcSel,
    output mipsCtrlPkg::aluOpE     aluOp,
    output logic                   aluBSel,   // 1 selects the immediate
    output logic                   dmWe,
    output mipsCtrlPkg::dmAlignE   dmAlign,
    output logic                   dmSign,
    output logic                   regWe,
    output mipsCtrlPkg::regAddrT   destReg,
    output mipsCtrlPkg::regWdSelE  regWdSel,
    output mipsCtrlPkg::stageCntT  rsTuse,
    output mipsCtrlPkg::stageCntT  rtTuse,
    output mipsCtrlPkg::stageCntT  tnew,
    output logic                   illegalInstr
);
    import mipsCtrlPkg::*;

    // main table, defaults describe an instruction that does nothing
    always_comb begin
        cmpOp        = cmpNone;
        extOp        = extZero;
        npcSel       = npcSeq;
        aluBSel      = 1'b0;
        dmWe         = 1'b0;
        regWe        = 1'b0;
        destReg      = '0;
        regWdSel     = wdAlu;
        rsTuse       = tuseNever;
        rtTuse       = tuseNever;
        tnew         = 2'd0;
        illegalInstr = 1'b0;
        case (kind)
            kindAdd, kindSub, kindAnd, kindOr, kindSlt, kindSltu: begin
                regWe   = 1'b1;
                destReg = rd;
                rsTuse  = 2'd1;
                rtTuse  = 2'd1;
                tnew    = 2'd1;
            end
            kindAddi, kindAndi, kindOri, kindLui: begin
                aluBSel = 1'b1;
                regWe   = 1'b1;
                destReg = rt;
                tnew    = 2'd1;
                if (kind == kindAddi) begin
                    extOp = extSign;
                end else if (kind == kindLui) begin
                    extOp = extHigh;   // imm goes to the upper half
                end
                if (kind != kindLui) begin
                    rsTuse = 2'd1;
                end
            end
            kindBeq, kindBne: begin
                cmpOp  = (kind == kindBeq) ? cmpEq : cmpNe;
                npcSel = npcBranch;
                rsTuse = 2'd0;   // compared in decode
                rtTuse = 2'd0;
            end
            kindJ, kindJal: begin
                npcSel = npcJumpInstr;
                if (kind == kindJal) begin
                    regWe    = 1'b1;
                    destReg  = raRegAddr;
                    regWdSel = wdPcPlus8;
                end
            end
            kindJr, kindJalr: begin
                npcSel = npcJumpReg;
                rsTuse = 2'd0;
                if (kind == kindJalr) begin
                    regWe    = 1'b1;
                    destReg  = rd;
                    regWdSel = wdPcPlus8;
                end
            end
            kindLw, kindLh, kindLhu, kindLb, kindLbu: begin
                extOp    = (kind == kindLhu || kind == kindLbu) ? extZero : extSign;
                aluBSel  = 1'b1;
                regWe    = 1'b1;
                destReg  = rt;
                regWdSel = wdMem;
                rsTuse   = 2'd1;
                tnew     = 2'd2;   // data only after memory
            end
            kindSw, kindSh, kindSb: begin
                extOp   = extSign;
                aluBSel = 1'b1;
                dmWe    = 1'b1;
                rsTuse  = 2'd1;
                rtTuse  = 2'd2;   // store data needed in memory stage
            end
            default: illegalInstr = 1'b1;
        endcase
    end

    // alu operation and memory access width
    always_comb begin
        aluOp   = aluAdd;
        dmAlign = alignWord;
        dmSign  = 1'b0;
        case (kind)
            kindSub:                  aluOp = aluSub;
            kindAnd, kindAndi:        aluOp = aluAnd;
            kindOr, kindOri, kindLui: aluOp = aluOr;
            kindSlt:                  aluOp = aluSlt;
            kindSltu:                 aluOp = aluSltu;
            kindLh: begin
                dmAlign = alignHalf;
                dmSign  = 1'b1;
            end
            kindLhu, kindSh:          dmAlign = alignHalf;
            kindLb: begin
                dmAlign = alignByte;
                dmSign  = 1'b1;
            end
            kindLbu, kindSb:          dmAlign = alignByte;
            default: ;
        endcase
    end

endmodule

// ==== rtl/hazardStall.sv ====
`timescale 1ns/1ns

module hazardStall (
    input  mipsCtrlPkg::regAddrT  rs,
    input  mipsCtrlPkg::regAddrT  rt,
    input  mipsCtrlPkg::stageCntT rsTuse,
    input  mipsCtrlPkg::stageCntT rtTuse,
    input  mipsCtrlPkg::regAddrT  destE,
    input  logic                  regWeE,
    input  mipsCtrlPkg::stageCntT tnewE,
    input  mipsCtrlPkg::regAddrT  destM,
    input  logic                  regWeM,
    input  mipsCtrlPkg::stageCntT tnewM,
    output logic                  stall
);
    import mipsCtrlPkg::*;

    // one source against the two producers in flight
    function automatic logic srcHazard(regAddrT src, stageCntT tuse);
        logic live;
        logic hitE;
        logic hitM;
        live = (src != '0) && (tuse != tuseNever);
        hitE = regWeE && (src == destE) && (tuse < tnewE);
        hitM = regWeM && (src == destM) && (tuse < tnewM);
        return live && (hitE || hitM);
    endfunction

    logic rsStall;
    logic rtStall;

    always_comb begin
        rsStall = srcHazard(rs, rsTuse);
        rtStall = srcHazard(rt, rtTuse);
        stall   = rsStall || rtStall;
    end

endmodule

// ==== rtl/controlPipe.sv ====
`timescale 1ns/1ns

module controlPipe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,     // decode instruction moves on
    input  mipsCtrlPkg::aluOpE    aluOpD,
    input  logic                  aluBSelD,
    input  logic                  dmWeD,
    input  mipsCtrlPkg::dmAlignE  dmAlignD,
    input  logic                  dmSignD,
    input  logic                  regWeD,
    input  mipsCtrlPkg::regAddrT  destD,
    input  mipsCtrlPkg::regWdSelE regWdSelD,
    input  mipsCtrlPkg::stageCntT tnewD,
    output mipsCtrlPkg::aluOpE    aluOp,
    output logic                  aluBSel,
    output logic                  dmWe,
    output mipsCtrlPkg::dmAlignE  dmAlign,
    output logic                  dmSign,
    output logic                  regWe,
    output mipsCtrlPkg::regAddrT  regWaddr,
    output mipsCtrlPkg::regWdSelE regWdSel,
    output mipsCtrlPkg::regAddrT  destE,
    output logic                  regWeE,
    output mipsCtrlPkg::stageCntT tnewE,
    output mipsCtrlPkg::regAddrT  destM,
    output logic                  regWeM,
    output mipsCtrlPkg::stageCntT tnewM
);
    import mipsCtrlPkg::*;

    // execute stage fields not visible at the ports
    logic     dmWeE;
    dmAlignE  alignE;
    logic     dmSignE;
    regWdSelE wdSelE;
    // memory stage
    regWdSelE wdSelM;

    // write enables, a bubble enters execute when nothing is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            regWeE <= 1'b0;
            dmWeE  <= 1'b0;
            regWeM <= 1'b0;
            dmWe   <= 1'b0;
            regWe  <= 1'b0;
        end else begin
            regWeE <= advance && regWeD;
            dmWeE  <= advance && dmWeD;
            regWeM <= regWeE;
            dmWe   <= dmWeE;
            regWe  <= regWeM;
        end
    end

    // payload, only meaningful behind a set enable
    always_ff @(posedge clk) begin
        aluOp    <= aluOpD;
        aluBSel  <= aluBSelD;
        alignE   <= dmAlignD;
        dmSignE  <= dmSignD;
        destE    <= destD;
        wdSelE   <= regWdSelD;
        tnewE    <= tnewD;

        dmAlign  <= alignE;
        dmSign   <= dmSignE;
        destM    <= destE;
        wdSelM   <= wdSelE;
        tnewM    <= (tnewE == 2'd0) ? 2'd0 : tnewE - 2'd1;   // one stage closer

        regWaddr <= destM;
        regWdSel <= wdSelM;
    end

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  mipsCtrlPkg::instrT    instr,
    input  logic                  instrValid,
    output logic                  instrReady,
    output logic                  illegalInstr,
    output mipsCtrlPkg::cmpOpE    cmpOp,
    output mipsCtrlPkg::extOpE    extOp,
    output mipsCtrlPkg::npcSelE   npcSel,
    output mipsCtrlPkg::aluOpE    aluOp,
    output logic                  aluBSel,
    output logic                  dmWe,
    output mipsCtrlPkg::dmAlignE  dmAlign,
    output logic                  dmSign,
    output logic                  regWe,
    output mipsCtrlPkg::regAddrT  regWaddr,
    output mipsCtrlPkg::regWdSelE regWdSel
);
    import mipsCtrlPkg::*;

    instrKindE kind;
    regAddrT   rs;
    regAddrT   rt;
    regAddrT   rd;

    // decode-stage fields headed down the pipe
    aluOpE     aluOpD;
    logic      aluBSelD;
    logic      dmWeD;
    dmAlignE   dmAlignD;
    logic      dmSignD;
    logic      regWeD;
    regAddrT   destD;
    regWdSelE  regWdSelD;
    stageCntT  rsTuse;
    stageCntT  rtTuse;
    stageCntT  tnewD;

    regAddrT   destE;
    regAddrT   destM;
    logic      regWeE;
    logic      regWeM;
    stageCntT  tnewE;
    stageCntT  tnewM;

    logic      stall;
    logic      advance;

    assign instrReady = !stall;
    assign advance    = instrValid && instrReady;

    instrDecode uDecode (.instr(instr), .kind(kind), .rs(rs), .rt(rt), .rd(rd));

    controlTable uTable (
        .kind(kind), .rt(rt), .rd(rd),
        .cmpOp(cmpOp), .extOp(extOp), .npcSel(npcSel),
        .aluOp(aluOpD), .aluBSel(aluBSelD),
        .dmWe(dmWeD), .dmAlign(dmAlignD), .dmSign(dmSignD),
        .regWe(regWeD), .destReg(destD), .regWdSel(regWdSelD),
        .rsTuse(rsTuse), .rtTuse(rtTuse), .tnew(tnewD),
        .illegalInstr(illegalInstr)
    );

    hazardStall uStall (
        .rs(rs), .rt(rt), .rsTuse(rsTuse), .rtTuse(rtTuse),
        .destE(destE), .regWeE(regWeE), .tnewE(tnewE),
        .destM(destM), .regWeM(regWeM), .tnewM(tnewM),
        .stall(stall)
    );

    // execute stage loads at the accepting edge
    controlPipe uPipe (
        .clk(clk), .rst(rst), .advance(advance),
        .aluOpD(aluOpD), .aluBSelD(aluBSelD), .dmWeD(dmWeD),
        .dmAlignD(dmAlignD), .dmSignD(dmSignD), .regWeD(regWeD),
        .destD(destD), .regWdSelD(regWdSelD), .tnewD(tnewD),
        .aluOp(aluOp), .aluBSel(aluBSel), .dmWe(dmWe),
        .dmAlign(dmAlign), .dmSign(dmSign), .regWe(regWe),
        .regWaddr(regWaddr), .regWdSel(regWdSel),
        .destE(destE), .regWeE(regWeE), .tnewE(tnewE),
        .destM(destM), .regWeM(regWeM), .tnewM(tnewM)
    );

endmodule

// ==== dv/controlUnit_properties.sv ====
`timescale 1ns/1ns

module controlUnitProperties (
    input logic clk,
    input logic rst,
    input logic instrReady,
    input logic stall,
    input logic advance,
    input logic regWeE,
    input logic regWeM,
    input logic dmWe,
    input logic regWe
);

    // reset empties every stage and opens the decode input
    resetClear: assert property (@(posedge clk)
        rst |=> instrReady && !regWeE && !dmWe && !regWe)
        else $error("write enable or stall left over from reset");

    // nothing accepted means a bubble in execute
    bubbleOnHold: assert property (@(posedge clk) disable iff (rst) !advance |=> !regWeE)
        else $error("execute stage writes after a cycle without acceptance");

    bubbleInMemory: assert property (@(posedge clk) disable iff (rst)
        !$past(advance) |=> !regWeM && !dmWe)   // same bubble one stage on
        else $error("memory stage writes two cycles after no acceptance");

    bubbleInWriteBack: assert property (@(posedge clk) disable iff (rst)
        !$past(advance, 2) |=> !regWe)
        else $error("write-back stage writes three cycles after no acceptance");

    stallBound: assert property (@(posedge clk) disable iff (rst)
        stall && $past(stall) |=> !stall)
        else $error("stall held for more than two cycles");

endmodule

bind controlUnit controlUnitProperties uProps (
    .clk(clk), .rst(rst), .instrReady(instrReady), .stall(stall),
    .advance(advance), .regWeE(regWeE), .regWeM(regWeM), .dmWe(dmWe), .regWe(regWe)
);

// ==== dv/controlModel.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

typedef struct packed {
    logic     valid;
    logic     illegal;
    cmpOpE    cmpOp;
    extOpE    extOp;
    npcSelE   npcSel;
    aluOpE    aluOp;
    logic     aluBSel;
    logic     dmWe;
    dmAlignE  dmAlign;
    logic     dmSign;
    logic     regWe;
    regAddrT  dest;
    regWdSelE wdSel;
    stageCntT rsTuse;
    stageCntT rtTuse;
    stageCntT tnew;
} ctrlT;

ctrlT stages[3];   // execute, memory, write-back

function automatic ctrlT expectCtrl(instrT w);
    ctrlT c;
    logic load;
    logic store;
    c = '0;
    c.valid   = 1'b1;
    c.cmpOp   = cmpNone;
    c.extOp   = extZero;
    c.npcSel  = npcSeq;
    c.aluOp   = aluAdd;
    c.dmAlign = alignWord;
    c.wdSel   = wdAlu;
    c.rsTuse  = tuseNever;
    c.rtTuse  = tuseNever;
    load  = w[31:26] inside {opLw, opLh, opLhu, opLb, opLbu};
    store = w[31:26] inside {opSw, opSh, opSb};
    if (load || store) begin
        // access width sits in the low opcode bits, bit 28 marks unsigned loads
        c.extOp   = (w[31:26] inside {opLhu, opLbu}) ? extZero : extSign;
        c.aluBSel = 1'b1;
        c.rsTuse  = 2'd1;
        c.dmAlign = (w[27:26] == 2'b11) ? alignWord : (w[26] ? alignHalf : alignByte);
        c.dmSign  = load && (w[27:26] != 2'b11) && !w[28];
        c.regWe   = load;
        c.dest    = w[20:16];
        c.wdSel   = wdMem;
        c.tnew    = load ? 2'd2 : 2'd0;
        c.dmWe    = store;
        c.rtTuse  = store ? 2'd2 : tuseNever;
    end else begin
        case (w[31:26])
            opZero: begin
                case (w[5:0])
                    functAdd, functSub, functAnd, functOr, functSlt, functSltu: begin
                        c.regWe  = 1'b1;
                        c.dest   = w[15:11];
                        c.rsTuse = 2'd1;
                        c.rtTuse = 2'd1;
                        c.tnew   = 2'd1;
                        case (w[5:0])
                            functSub:  c.aluOp = aluSub;
                            functAnd:  c.aluOp = aluAnd;
                            functOr:   c.aluOp = aluOr;
                            functSlt:  c.aluOp = aluSlt;
                            functSltu: c.aluOp = aluSltu;
                            default:   c.aluOp = aluAdd;
                        endcase
                    end
                    functJr, functJalr: begin
                        c.npcSel = npcJumpReg;
                        c.rsTuse = 2'd0;
                        c.regWe  = w[0];   // jalr links
                        c.dest   = w[15:11];
                        c.wdSel  = wdPcPlus8;
                    end
                    default: c.illegal = 1'b1;
                endcase
            end
            opAddi, opAndi, opOri, opLui: begin
                c.aluBSel = 1'b1;
                c.regWe   = 1'b1;
                c.dest    = w[20:16];
                c.tnew    = 2'd1;
                c.rsTuse  = (w[31:26] == opLui) ? tuseNever : 2'd1;
                c.extOp   = (w[31:26] == opAddi) ? extSign : extZero;
                c.aluOp   = (w[31:26] == opAndi) ? aluAnd : aluOr;
                if (w[31:26] == opAddi) begin
                    c.aluOp = aluAdd;
                end
                if (w[31:26] == opLui) begin
                    c.extOp = extHigh;
                end
            end
            opBeq, opBne: begin
                c.cmpOp  = w[26] ? cmpNe : cmpEq;
                c.npcSel = npcBranch;
                c.rsTuse = 2'd0;
                c.rtTuse = 2'd0;
            end
            opJ, opJal: begin
                c.npcSel = npcJumpInstr;
                c.regWe  = w[26];
                c.dest   = raRegAddr;
                c.wdSel  = wdPcPlus8;
            end
            default: c.illegal = 1'b1;
        endcase
    end
    return c;
endfunction

// source waits on a producer in execute or memory
function automatic logic sourceWaits(regAddrT src, stageCntT tuse);
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < 2; s++) begin
        if (stages[s].regWe && stages[s].dest == src && tuse < stages[s].tnew) begin
            hit = 1'b1;
        end
    end
    return hit && (src != 5'd0) && (tuse != tuseNever);
endfunction

function automatic logic expectStall(instrT w);
    ctrlT c;
    c = expectCtrl(w);
    return sourceWaits(w[25:21], c.rsTuse) || sourceWaits(w[20:16], c.rtTuse);
endfunction

task automatic advanceStages(input logic accept, input ctrlT d);
    stages[2] = stages[1];
    stages[1] = stages[0];
    stages[1].tnew = (stages[1].tnew == 2'd0) ? 2'd0 : stages[1].tnew - 2'd1;
    stages[0] = accept ? d : '0;   // bubble otherwise
endtask

task automatic clearStages();
    for (int s = 0; s < 3; s++) begin
        stages[s] = '0;
    end
endtask

`endif

// ==== dv/controlUnitTb.sv ====
`timescale 1ns/1ns

module controlUnitTb;
    import mipsCtrlPkg::*;

    `include "controlModel.svh"

    localparam int numInstr   = 2000;
    localparam int cycleLimit = 16 + 3 * numInstr + 20;

    localparam opcodeT immOps[16] = '{opAddi, opAndi, opOri, opLui, opBeq, opBne, opJ, opJal,
                                      opLw, opLh, opLhu, opLb, opLbu, opSw, opSh, opSb};
    localparam functT rFuncts[8] = '{functAdd, functSub, functAnd, functOr,
                                     functSlt, functSltu, functJr, functJalr};

    logic     clk = 1'b0;
    logic     rst;
    instrT    instr;
    logic     instrValid;
    logic     instrReady;
    logic     illegalInstr;
    cmpOpE    cmpOp;
    extOpE    extOp;
    npcSelE   npcSel;
    aluOpE    aluOp;
    logic     aluBSel;
    logic     dmWe;
    dmAlignE  dmAlign;
    logic     dmSign;
    logic     regWe;
    regAddrT  regWaddr;
    regWdSelE regWdSel;

    int errors   = 0;
    int checks   = 0;
    int cycles   = 0;
    int accepted = 0;

    always #50 clk = ~clk;

    controlUnit DUT (
        .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
        .instrReady(instrReady), .illegalInstr(illegalInstr),
        .cmpOp(cmpOp), .extOp(extOp), .npcSel(npcSel),
        .aluOp(aluOp), .aluBSel(aluBSel),
        .dmWe(dmWe), .dmAlign(dmAlign), .dmSign(dmSign),
        .regWe(regWe), .regWaddr(regWaddr), .regWdSel(regWdSel)
    );

    task automatic reportMismatch(string test, string field, string expStr, string actStr);
        errors++;
        $display("[FAIL] %s %s: expected %s, actual %s", test, field, expStr, actStr);
    endtask

    task automatic checkDecode(string test, cmpOpE expCmp, extOpE expExt, npcSelE expNpc,
                               logic expIll, cmpOpE actCmp, extOpE actExt, npcSelE actNpc,
                               logic actIll);
        checks++;
        if (actCmp !== expCmp) reportMismatch(test, "cmpOp", expCmp.name(), actCmp.name());
        if (actExt !== expExt) reportMismatch(test, "extOp", expExt.name(), actExt.name());
        if (actNpc !== expNpc) reportMismatch(test, "npcSel", expNpc.name(), actNpc.name());
        if (actIll !== expIll) begin
            reportMismatch(test, "illegalInstr", $sformatf("%b", expIll), $sformatf("%b", actIll));
        end
    endtask

    task automatic checkExecute(string test, logic live, aluOpE expOp, logic expBSel,
                                aluOpE actOp, logic actBSel);
        checks++;
        if (live && actOp !== expOp) reportMismatch(test, "aluOp", expOp.name(), actOp.name());
        if (live && actBSel !== expBSel) begin
            reportMismatch(test, "aluBSel", $sformatf("%b", expBSel), $sformatf("%b", actBSel));
        end
    endtask

    task automatic checkMemory(string test, logic live, logic expWe, dmAlignE expAlign,
                               logic expSign, logic actWe, dmAlignE actAlign, logic actSign);
        checks++;
        if (actWe !== expWe) reportMismatch(test, "dmWe", $sformatf("%b", expWe), $sformatf("%b", actWe));
        if (live && actAlign !== expAlign) begin
            reportMismatch(test, "dmAlign", expAlign.name(), actAlign.name());
        end
        if (live && actSign !== expSign) begin
            reportMismatch(test, "dmSign", $sformatf("%b", expSign), $sformatf("%b", actSign));
        end
    endtask

    task automatic checkWriteBack(string test, logic expWe, regAddrT expAddr, regWdSelE expSel,
                                  logic actWe, regAddrT actAddr, regWdSelE actSel);
        checks++;
        if (actWe !== expWe) reportMismatch(test, "regWe", $sformatf("%b", expWe), $sformatf("%b", actWe));
        if (expWe && actAddr !== expAddr) begin
            reportMismatch(test, "regWaddr", $sformatf("%0d", expAddr), $sformatf("%0d", actAddr));
        end
        if (expWe && actSel !== expSel) reportMismatch(test, "regWdSel", expSel.name(), actSel.name());
    endtask

    task automatic checkStall(string test, logic expReady, logic actReady);
        checks++;
        if (actReady !== expReady) begin
            reportMismatch(test, "instrReady", $sformatf("%b", expReady), $sformatf("%b", actReady));
        end
    endtask

    // registers mostly from a small set so hazards are common
    function automatic regAddrT randomReg();
        return ($urandom % 16 == 0) ? raRegAddr : regAddrT'($urandom % 4);
    endfunction

    function automatic instrT randomWord();
        instrT word;
        case ($urandom % 4)
            0: word = $urandom;   // mostly undefined encodings
            1: word = {opZero, randomReg(), randomReg(), randomReg(), 5'($urandom),
                       rFuncts[3'($urandom)]};
            default: word = {immOps[4'($urandom)], randomReg(), randomReg(), 16'($urandom)};
        endcase
        return word;
    endfunction

    // outputs are sampled at the falling edge
    task automatic checkCycle(string test);
        ctrlT d;
        d = expectCtrl(instr);
        if (instrValid) begin
            checkDecode(test, d.cmpOp, d.extOp, d.npcSel, d.illegal,
                        cmpOp, extOp, npcSel, illegalInstr);
        end
        checkStall(test, !expectStall(instr), instrReady);
        checkExecute(test, stages[0].valid, stages[0].aluOp, stages[0].aluBSel, aluOp, aluBSel);
        checkMemory(test, stages[1].valid, stages[1].dmWe, stages[1].dmAlign, stages[1].dmSign,
                    dmWe, dmAlign, dmSign);
        checkWriteBack(test, stages[2].regWe, stages[2].dest, stages[2].wdSel,
                       regWe, regWaddr, regWdSel);
    endtask

    task automatic stepModel(input logic offer);
        logic accept;
        accept = instrValid && !expectStall(instr);
        advanceStages(accept, expectCtrl(instr));
        if (accept) accepted++;
        if (!offer) begin
            instrValid <= 1'b0;
        end else if (!(instrValid && !accept)) begin   // a pending offer is held
            instr      <= randomWord();
            instrValid <= ($urandom % 8) != 0;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: %0d cycles passed with %0d instructions accepted", cycles, accepted);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h056110f5));
        rst        <= 1'b1;
        instr      <= '0;
        instrValid <= 1'b0;
        clearStages();
        for (int i = 1; i <= 16; i++) begin
            @(posedge clk);
            rst <= (i < 16);
            @(negedge clk);
            checkCycle("reset");
        end
        while (accepted < numInstr) begin
            @(posedge clk);
            stepModel(1'b1);
            @(negedge clk);
            checkCycle("random");
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            stepModel(1'b0);
            @(negedge clk);
            checkCycle("drain");
        end
        $display("checks %0d, errors %0d, accepted %0d", checks, errors, accepted);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+dv
rtl/mipsCtrlPkg.sv
rtl/instrDecode.sv
rtl/controlTable.sv
rtl/hazardStall.sv
rtl/controlPipe.sv
rtl/controlUnit.sv
dv/controlUnit_properties.sv
dv/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the controlUnit testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/1ns --top-module controlUnitTb -f all.f \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VcontrolUnitTb > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
